/* src/mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

`default_nettype none

// ==================
// bus widths
// ==================
`define MEM_ADDR_WIDTH 64
`define MEM_DATA_WIDTH 64
`define MEM_STRB_WIDTH (`MEM_DATA_WIDTH / 8)
`define MEM_ID_WIDTH 4

// ==================
// data cache geometry
// ==================
// 16 lines of one 64-bit word each
`define MEM_DCACHE_INDEX_BITS 4
`define MEM_DCACHE_OFFSET_BITS 3

`default_nettype wire

`endif

/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // funct3 field of RISC-V loads and stores
    typedef enum logic [2:0] {
        f3ls_b  = 3'b000,
        f3ls_h  = 3'b001,
        f3ls_w  = 3'b010,
        f3ls_d  = 3'b011,
        f3ls_bu = 3'b100,
        f3ls_hu = 3'b101,
        f3ls_wu = 3'b110
    } ls_width_e;

    // what the memory stage needs from the decoder
    typedef struct packed {
        logic      is_load;
        logic      is_store;
        ls_width_e funct3;
    } decoded_inst_t;

    // AXI response codes on b and r
    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_e;

endpackage

`default_nettype wire

/* src/dcache_req_if.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"
`default_nettype none

interface dcache_req_if;

    // stage to cache
    logic                       enable;
    logic                       wrn;
    logic [`MEM_ADDR_WIDTH-1:0] addr;
    logic [`MEM_DATA_WIDTH-1:0] wdata;
    logic [1:0]                 wlen;

    // cache to stage
    logic [`MEM_DATA_WIDTH-1:0] rdata;
    logic                       valid;
    logic                       write_done;

    modport stage (
        output enable, wrn, addr, wdata, wlen,
        input  rdata, valid, write_done
    );

    modport cache (
        input  enable, wrn, addr, wdata, wlen,
        output rdata, valid, write_done
    );

endinterface

`default_nettype wire

/* src/mem_stage.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"
`default_nettype none

module mem_stage (
    input  mem_pkg::decoded_inst_t     inst,
    input  logic [`MEM_ADDR_WIDTH-1:0] ex_data,
    input  logic [`MEM_DATA_WIDTH-1:0] ex_data2,
    input  logic                       is_bubble,
    output logic [`MEM_DATA_WIDTH-1:0] mem_ex_rdata,
    output logic                       dcache_en,
    dcache_req_if.stage                req
);

    logic [`MEM_DCACHE_OFFSET_BITS+2:0] shift_amt;
    logic [`MEM_DATA_WIDTH-1:0]         rdata_shifted;
    logic [`MEM_DATA_WIDTH-1:0]         wdata_trim;

    assign dcache_en = (inst.is_load || inst.is_store) && !is_bubble;

    // ==================
    // request side
    // ==================
    assign req.enable = dcache_en;
    assign req.wrn    = inst.is_store;
    assign req.addr   = ex_data;
    assign req.wdata  = wdata_trim;
    // the cache needs only the size code
    assign req.wlen   = inst.funct3[1:0];

    // operand stays unshifted and the cache places it in the word
    always_comb begin
        case (inst.funct3)
            mem_pkg::f3ls_b: wdata_trim = {56'd0, ex_data2[7:0]};
            mem_pkg::f3ls_h: wdata_trim = {48'd0, ex_data2[15:0]};
            mem_pkg::f3ls_w: wdata_trim = {32'd0, ex_data2[31:0]};
            mem_pkg::f3ls_d: wdata_trim = ex_data2;
            default:         wdata_trim = ex_data2;
        endcase
    end

    // ==================
    // load side
    // ==================
    // byte offset in bits
    assign shift_amt     = {ex_data[`MEM_DCACHE_OFFSET_BITS-1:0], 3'b000};
    assign rdata_shifted = req.rdata >> shift_amt;

    always_comb begin
        case (inst.funct3)
            mem_pkg::f3ls_b:  mem_ex_rdata = {{56{rdata_shifted[7]}}, rdata_shifted[7:0]};
            mem_pkg::f3ls_h:  mem_ex_rdata = {{48{rdata_shifted[15]}}, rdata_shifted[15:0]};
            mem_pkg::f3ls_w:  mem_ex_rdata = {{32{rdata_shifted[31]}}, rdata_shifted[31:0]};
            mem_pkg::f3ls_bu: mem_ex_rdata = {56'd0, rdata_shifted[7:0]};
            mem_pkg::f3ls_hu: mem_ex_rdata = {48'd0, rdata_shifted[15:0]};
            mem_pkg::f3ls_wu: mem_ex_rdata = {32'd0, rdata_shifted[31:0]};
            // double word
            default:          mem_ex_rdata = req.rdata;
        endcase
    end

endmodule

`default_nettype wire

/* src/dcache.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"
`default_nettype none

module dcache (
    input  logic                       clk,
    input  logic                       rst_n,
    dcache_req_if.cache                req,

    output logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_awid,
    output logic [`MEM_ADDR_WIDTH-1:0] dcache_m_axi_awaddr,
    output logic [7:0]                 dcache_m_axi_awlen,
    output logic [2:0]                 dcache_m_axi_awsize,
    output logic [1:0]                 dcache_m_axi_awburst,
    output logic                       dcache_m_axi_awvalid,
    input  logic                       dcache_m_axi_awready,
    output logic [`MEM_DATA_WIDTH-1:0] dcache_m_axi_wdata,
    output logic [`MEM_STRB_WIDTH-1:0] dcache_m_axi_wstrb,
    output logic                       dcache_m_axi_wlast,
    output logic                       dcache_m_axi_wvalid,
    input  logic                       dcache_m_axi_wready,
    input  logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_bid,
    input  logic [1:0]                 dcache_m_axi_bresp,
    input  logic                       dcache_m_axi_bvalid,
    output logic                       dcache_m_axi_bready,
    output logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_arid,
    output logic [`MEM_ADDR_WIDTH-1:0] dcache_m_axi_araddr,
    output logic [7:0]                 dcache_m_axi_arlen,
    output logic [2:0]                 dcache_m_axi_arsize,
    output logic [1:0]                 dcache_m_axi_arburst,
    output logic                       dcache_m_axi_arvalid,
    input  logic                       dcache_m_axi_arready,
    input  logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_rid,
    input  logic [`MEM_DATA_WIDTH-1:0] dcache_m_axi_rdata,
    input  logic [1:0]                 dcache_m_axi_rresp,
    input  logic                       dcache_m_axi_rlast,
    input  logic                       dcache_m_axi_rvalid,
    output logic                       dcache_m_axi_rready
);

    localparam int INDEX_BITS  = `MEM_DCACHE_INDEX_BITS;
    localparam int OFFSET_BITS = `MEM_DCACHE_OFFSET_BITS;
    localparam int TAG_BITS    = `MEM_ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int LINES       = 1 << INDEX_BITS;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_read_addr,
        st_read_data,
        st_write_req,
        st_write_resp,
        st_done
    } state_e;

    state_e state;

    // request as seen when the access started
    logic [`MEM_ADDR_WIDTH-1:0] addr_q;
    logic [`MEM_DATA_WIDTH-1:0] wdata_q;
    logic [1:0]                 wlen_q;
    logic                       wrn_q;

    logic [TAG_BITS-1:0]        tag_mem [LINES];
    logic [`MEM_DATA_WIDTH-1:0] data_mem [LINES];
    logic [LINES-1:0]           line_valid;

    logic [INDEX_BITS-1:0]      index;
    logic [TAG_BITS-1:0]        tag;
    logic                       hit;
    logic [`MEM_DATA_WIDTH-1:0] rdata_q;
    logic                       valid_q;
    logic                       write_done_q;
    logic                       aw_pend;
    logic                       w_pend;
    logic [`MEM_DATA_WIDTH-1:0] wdata_aligned;
    logic [`MEM_STRB_WIDTH-1:0] strb_base;
    logic [`MEM_STRB_WIDTH-1:0] strb;
    mem_pkg::axi_resp_e         rresp;
    mem_pkg::axi_resp_e         bresp;
    logic                       r_fire;
    logic                       b_fire;
    logic                       r_ok;
    logic                       b_ok;

    assign index = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign tag   = addr_q[`MEM_ADDR_WIDTH-1 -: TAG_BITS];
    assign hit   = line_valid[index] && (tag_mem[index] == tag);

    assign rresp  = mem_pkg::axi_resp_e'(dcache_m_axi_rresp);
    assign bresp  = mem_pkg::axi_resp_e'(dcache_m_axi_bresp);
    assign r_ok   = (rresp == mem_pkg::okay) || (rresp == mem_pkg::exokay);
    assign b_ok   = (bresp == mem_pkg::okay) || (bresp == mem_pkg::exokay);
    assign r_fire = dcache_m_axi_rvalid && dcache_m_axi_rready && dcache_m_axi_rlast;
    assign b_fire = dcache_m_axi_bvalid && dcache_m_axi_bready;

    // byte lanes of the store
    always_comb begin
        case (wlen_q)
            2'b00:   strb_base = 8'h01;
            2'b01:   strb_base = 8'h03;
            2'b10:   strb_base = 8'h0f;
            default: strb_base = 8'hff;
        endcase
    end

    assign strb          = strb_base << addr_q[OFFSET_BITS-1:0];
    assign wdata_aligned = wdata_q << {addr_q[OFFSET_BITS-1:0], 3'b000};

    // ==================
    // control FSM
    // ==================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            aw_pend      <= 1'b0;
            w_pend       <= 1'b0;
            valid_q      <= 1'b0;
            write_done_q <= 1'b0;
        end else begin
            valid_q      <= 1'b0;
            write_done_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (req.enable) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (wrn_q) begin
                        state   <= st_write_req;
                        aw_pend <= 1'b1;
                        w_pend  <= 1'b1;
                    end else if (hit) begin
                        state <= st_done;
                    end else begin
                        state <= st_read_addr;
                    end
                end
                st_read_addr: begin
                    if (dcache_m_axi_arready) begin
                        state <= st_read_data;
                    end
                end
                st_read_data: begin
                    if (r_fire) begin
                        state   <= st_done;
                        valid_q <= 1'b1;
                    end
                end
                st_write_req: begin
                    // aw and w may be taken in different cycles
                    if (dcache_m_axi_awready) begin
                        aw_pend <= 1'b0;
                    end
                    if (dcache_m_axi_wready) begin
                        w_pend <= 1'b0;
                    end
                    if ((!aw_pend || dcache_m_axi_awready) && (!w_pend || dcache_m_axi_wready)) begin
                        state <= st_write_resp;
                    end
                end
                st_write_resp: begin
                    if (b_fire) begin
                        state        <= st_done;
                        write_done_q <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // tags only become valid through a clean fill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else if (r_fire && r_ok) begin
            line_valid[index] <= 1'b1;
        end
    end

    // ==================
    // payload and arrays
    // ==================
    always_ff @(posedge clk) begin
        if (state == st_idle && req.enable) begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
            wlen_q  <= req.wlen;
            wrn_q   <= req.wrn;
        end
        if (r_fire) begin
            rdata_q <= dcache_m_axi_rdata;
        end
        if (r_fire && r_ok) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= dcache_m_axi_rdata;
        end
        // write-through hit updates the cached copy
        if (b_fire && b_ok && hit) begin
            for (int i = 0; i < `MEM_STRB_WIDTH; i++) begin
                if (strb[i]) begin
                    data_mem[index][8*i +: 8] <= wdata_aligned[8*i +: 8];
                end
            end
        end
    end

    assign req.rdata      = (state == st_lookup) ? data_mem[index] : rdata_q;
    assign req.valid      = valid_q || (state == st_lookup && !wrn_q && hit);
    assign req.write_done = write_done_q;

    // ==================
    // AXI master
    // ==================
    // Single beat of 8 bytes, fixed id
    assign dcache_m_axi_awid    = '0;
    assign dcache_m_axi_awaddr  = {addr_q[`MEM_ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign dcache_m_axi_awlen   = 8'd0;
    assign dcache_m_axi_awsize  = 3'd3;
    assign dcache_m_axi_awburst = 2'b01;
    assign dcache_m_axi_awvalid = aw_pend;
    assign dcache_m_axi_wdata   = wdata_aligned;
    assign dcache_m_axi_wstrb   = strb;
    assign dcache_m_axi_wlast   = 1'b1;
    assign dcache_m_axi_wvalid  = w_pend;
    assign dcache_m_axi_bready  = (state == st_write_resp);
    assign dcache_m_axi_arid    = '0;
    assign dcache_m_axi_araddr  = {addr_q[`MEM_ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign dcache_m_axi_arlen   = 8'd0;
    assign dcache_m_axi_arsize  = 3'd3;
    assign dcache_m_axi_arburst = 2'b01;
    assign dcache_m_axi_arvalid = (state == st_read_addr);
    assign dcache_m_axi_rready  = (state == st_read_data);

endmodule

`default_nettype wire

/* src/mem_subsystem_top.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"
`default_nettype none

module mem_subsystem_top (
    input  logic                       clk,
    input  logic                       rst_n,

    // pipeline side
    input  mem_pkg::decoded_inst_t     inst,
    input  logic [`MEM_ADDR_WIDTH-1:0] ex_data,
    input  logic [`MEM_DATA_WIDTH-1:0] ex_data2,
    input  logic                       is_bubble,
    output logic [`MEM_DATA_WIDTH-1:0] mem_ex_rdata,
    output logic                       dcache_en,
    output logic                       dcache_valid,
    output logic                       write_done,

    // AXI master
    output logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_awid,
    output logic [`MEM_ADDR_WIDTH-1:0] dcache_m_axi_awaddr,
    output logic [7:0]                 dcache_m_axi_awlen,
    output logic [2:0]                 dcache_m_axi_awsize,
    output logic [1:0]                 dcache_m_axi_awburst,
    output logic                       dcache_m_axi_awvalid,
    input  logic                       dcache_m_axi_awready,
    output logic [`MEM_DATA_WIDTH-1:0] dcache_m_axi_wdata,
    output logic [`MEM_STRB_WIDTH-1:0] dcache_m_axi_wstrb,
    output logic                       dcache_m_axi_wlast,
    output logic                       dcache_m_axi_wvalid,
    input  logic                       dcache_m_axi_wready,
    input  logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_bid,
    input  logic [1:0]                 dcache_m_axi_bresp,
    input  logic                       dcache_m_axi_bvalid,
    output logic                       dcache_m_axi_bready,
    output logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_arid,
    output logic [`MEM_ADDR_WIDTH-1:0] dcache_m_axi_araddr,
    output logic [7:0]                 dcache_m_axi_arlen,
    output logic [2:0]                 dcache_m_axi_arsize,
    output logic [1:0]                 dcache_m_axi_arburst,
    output logic                       dcache_m_axi_arvalid,
    input  logic                       dcache_m_axi_arready,
    input  logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_rid,
    input  logic [`MEM_DATA_WIDTH-1:0] dcache_m_axi_rdata,
    input  logic [1:0]                 dcache_m_axi_rresp,
    input  logic                       dcache_m_axi_rlast,
    input  logic                       dcache_m_axi_rvalid,
    output logic                       dcache_m_axi_rready
);

    dcache_req_if req ();

    mem_stage stage (
        .req(req),
        .*
    );

    dcache dcache (
        .req(req),
        .*
    );

    // completion strobes for the pipeline
    assign dcache_valid = req.valid;
    assign write_done   = req.write_done;

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"
`default_nettype none

module axi_mem_model (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`MEM_ADDR_WIDTH-1:0] dcache_m_axi_awaddr,
    input  logic                       dcache_m_axi_awvalid,
    output logic                       dcache_m_axi_awready,
    input  logic [`MEM_DATA_WIDTH-1:0] dcache_m_axi_wdata,
    input  logic [`MEM_STRB_WIDTH-1:0] dcache_m_axi_wstrb,
    input  logic                       dcache_m_axi_wvalid,
    output logic                       dcache_m_axi_wready,
    output logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_bid,
    output logic [1:0]                 dcache_m_axi_bresp,
    output logic                       dcache_m_axi_bvalid,
    input  logic                       dcache_m_axi_bready,
    input  logic [`MEM_ADDR_WIDTH-1:0] dcache_m_axi_araddr,
    input  logic                       dcache_m_axi_arvalid,
    output logic                       dcache_m_axi_arready,
    output logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_rid,
    output logic [`MEM_DATA_WIDTH-1:0] dcache_m_axi_rdata,
    output logic [1:0]                 dcache_m_axi_rresp,
    output logic                       dcache_m_axi_rlast,
    output logic                       dcache_m_axi_rvalid,
    input  logic                       dcache_m_axi_rready,
    output int                         ar_count,
    output int                         aw_count
);

    // 256 words, indexed by address bits [10:3]
    logic [`MEM_DATA_WIDTH-1:0] words [256];

    logic [7:0]                 aw_idx;
    logic [`MEM_DATA_WIDTH-1:0] w_data;
    logic [`MEM_STRB_WIDTH-1:0] w_strb;
    logic                       aw_got;
    logic                       w_got;
    int                         aw_wait;
    int                         w_wait;
    int                         ar_wait;

    // every byte lane depends on the whole word address
    initial begin
        logic [7:0] a;
        for (int i = 0; i < 256; i++) begin
            a = i[7:0];
            words[i] = {a ^ 8'h5a, ~a, a + 8'h81, a, 8'hf0 - a, a ^ 8'hc3, ~(a + 8'h17), a};
        end
    end

    // ==================
    // write side
    // ==================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dcache_m_axi_awready <= 1'b0;
            dcache_m_axi_wready  <= 1'b0;
            dcache_m_axi_bvalid  <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            aw_wait  <= 1;
            w_wait   <= 2;
            aw_count <= 0;
        end else begin
            if (dcache_m_axi_awvalid && dcache_m_axi_awready) begin
                dcache_m_axi_awready <= 1'b0;
                aw_got   <= 1'b1;
                aw_idx   <= dcache_m_axi_awaddr[10:3];
                aw_wait  <= $urandom_range(3, 0);
                aw_count <= aw_count + 1;
            end else if (dcache_m_axi_awvalid && !aw_got) begin
                if (aw_wait == 0) begin
                    dcache_m_axi_awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 1;
                end
            end
            if (dcache_m_axi_wvalid && dcache_m_axi_wready) begin
                dcache_m_axi_wready <= 1'b0;
                w_got  <= 1'b1;
                w_data <= dcache_m_axi_wdata;
                w_strb <= dcache_m_axi_wstrb;
                w_wait <= $urandom_range(3, 0);
            end else if (dcache_m_axi_wvalid && !w_got) begin
                if (w_wait == 0) begin
                    dcache_m_axi_wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 1;
                end
            end
            // commit once address and data are both in
            if (aw_got && w_got && !dcache_m_axi_bvalid) begin
                for (int k = 0; k < `MEM_STRB_WIDTH; k++) begin
                    if (w_strb[k]) begin
                        words[aw_idx][8*k +: 8] <= w_data[8*k +: 8];
                    end
                end
                dcache_m_axi_bvalid <= 1'b1;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
            if (dcache_m_axi_bvalid && dcache_m_axi_bready) begin
                dcache_m_axi_bvalid <= 1'b0;
            end
        end
    end

    // ==================
    // read side
    // ==================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dcache_m_axi_arready <= 1'b0;
            dcache_m_axi_rvalid  <= 1'b0;
            dcache_m_axi_rdata   <= '0;
            ar_wait  <= 1;
            ar_count <= 0;
        end else begin
            if (dcache_m_axi_arvalid && dcache_m_axi_arready) begin
                dcache_m_axi_arready <= 1'b0;
                dcache_m_axi_rvalid  <= 1'b1;
                dcache_m_axi_rdata   <= words[dcache_m_axi_araddr[10:3]];
                ar_wait  <= $urandom_range(3, 0);
                ar_count <= ar_count + 1;
            end else if (dcache_m_axi_arvalid && !dcache_m_axi_rvalid) begin
                if (ar_wait == 0) begin
                    dcache_m_axi_arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end
            if (dcache_m_axi_rvalid && dcache_m_axi_rready) begin
                dcache_m_axi_rvalid <= 1'b0;
            end
        end
    end

    assign dcache_m_axi_bid   = '0;
    assign dcache_m_axi_bresp = mem_pkg::okay;
    assign dcache_m_axi_rid   = '0;
    assign dcache_m_axi_rresp = mem_pkg::okay;
    assign dcache_m_axi_rlast = 1'b1;

endmodule

`default_nettype wire

/* sim/tb_mem_subsystem.sv */
`timescale 1ns/1ns
`include "mem_settings.svh"
`default_nettype none

module tb_mem_subsystem;

    typedef enum logic [1:0] {op_load, op_store, op_hold} op_e;

    typedef struct packed {
        op_e                        op;
        mem_pkg::ls_width_e         f3;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`MEM_DATA_WIDTH-1:0] data;
        logic                       miss;
    } step_t;

    logic                       clk;
    logic                       rst_n;
    mem_pkg::decoded_inst_t     inst;
    logic [`MEM_ADDR_WIDTH-1:0] ex_data;
    logic [`MEM_DATA_WIDTH-1:0] ex_data2;
    logic                       is_bubble;
    logic [`MEM_DATA_WIDTH-1:0] mem_ex_rdata;
    logic                       dcache_en, dcache_valid, write_done;

    logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_awid, dcache_m_axi_bid;
    logic [`MEM_ID_WIDTH-1:0]   dcache_m_axi_arid, dcache_m_axi_rid;
    logic [`MEM_ADDR_WIDTH-1:0] dcache_m_axi_awaddr, dcache_m_axi_araddr;
    logic [7:0]                 dcache_m_axi_awlen, dcache_m_axi_arlen;
    logic [2:0]                 dcache_m_axi_awsize, dcache_m_axi_arsize;
    logic [1:0]                 dcache_m_axi_awburst, dcache_m_axi_arburst;
    logic [`MEM_DATA_WIDTH-1:0] dcache_m_axi_wdata, dcache_m_axi_rdata;
    logic [`MEM_STRB_WIDTH-1:0] dcache_m_axi_wstrb;
    logic [1:0]                 dcache_m_axi_bresp, dcache_m_axi_rresp;
    logic                       dcache_m_axi_awvalid, dcache_m_axi_awready;
    logic                       dcache_m_axi_wvalid, dcache_m_axi_wready, dcache_m_axi_wlast;
    logic                       dcache_m_axi_bvalid, dcache_m_axi_bready;
    logic                       dcache_m_axi_arvalid, dcache_m_axi_arready;
    logic                       dcache_m_axi_rvalid, dcache_m_axi_rready, dcache_m_axi_rlast;
    int                         ar_count, aw_count;

    logic [`MEM_DATA_WIDTH-1:0] ref_mem [256];
    step_t                      steps [$];

    mem_subsystem_top UUT (.*);

    axi_mem_model mem (.*);

    always #50 clk = ~clk;

    // ==================
    // checks
    // ==================
    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input logic [63:0] expected, input logic [63:0] actual,
                              input string what);
        if (actual !== expected) begin
            $display("Fail %0t: %s expected %h got %h", $time, what, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_count(input int expected, input int actual, input string what);
        if (actual != expected) begin
            $display("Fail %0t: %s expected %0d got %0d", $time, what, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("Fail %0t: %s expected %b got %b", $time, what, expected, actual);
            stop_run();
        end
    endtask

    // single aligned 8-byte INCR beat with id 0
    task automatic axi_beat_compare(input logic [`MEM_ID_WIDTH-1:0] id,
                                    input logic [7:0] len, input logic [2:0] size,
                                    input logic [1:0] burst,
                                    input logic [`MEM_ADDR_WIDTH-1:0] addr,
                                    input string chan);
        if (id !== '0 || len !== 8'd0 || size !== 3'd3 || burst !== 2'b01 ||
            addr[2:0] !== 3'b000) begin
            $display("Fail %0t: %s beat id %h len %0d size %0d burst %b addr %h",
                     $time, chan, id, len, size, burst, addr);
            stop_run();
        end
    endtask

    // shift to the byte offset, then fill above the access width
    function automatic logic [63:0] extend_expect(input logic [63:0] word,
                                                  input logic [2:0] off,
                                                  input mem_pkg::ls_width_e f3);
        logic [63:0] v;
        logic [2:0]  code;
        int          bits;
        code = f3;
        v    = word >> (8 * off);
        bits = 8 << code[1:0];
        for (int b = bits; b < 64; b++) begin
            v[b] = code[2] ? 1'b0 : v[bits-1];
        end
        return v;
    endfunction

    task automatic check_width_ext(input mem_pkg::ls_width_e f3, input logic [63:0] word,
                                   input logic [2:0] off, input logic [63:0] actual);
        logic [63:0] expected;
        expected = extend_expect(word, off, f3);
        if (actual !== expected) begin
            $display("Fail %0t: %s load at offset %0d expected %h got %h",
                     $time, f3.name(), off, expected, actual);
            stop_run();
        end
    endtask

    // attributes of every beat the cache offers
    always @(negedge clk) begin
        if (rst_n && dcache_m_axi_arvalid) begin
            axi_beat_compare(dcache_m_axi_arid, dcache_m_axi_arlen, dcache_m_axi_arsize,
                             dcache_m_axi_arburst, dcache_m_axi_araddr, "AR");
        end
        if (rst_n && dcache_m_axi_awvalid) begin
            axi_beat_compare(dcache_m_axi_awid, dcache_m_axi_awlen, dcache_m_axi_awsize,
                             dcache_m_axi_awburst, dcache_m_axi_awaddr, "AW");
        end
        if (rst_n && dcache_m_axi_wvalid) begin
            check_flag(1'b1, dcache_m_axi_wlast, "wlast on the only W beat");
        end
    end

    // ==================
    // stimulus
    // ==================
    function automatic void add_step(input op_e op, input mem_pkg::ls_width_e f3,
                                     input logic [63:0] addr, input logic [63:0] data,
                                     input logic miss);
        steps.push_back({op, f3, addr, data, miss});
    endfunction

    task automatic run_step(input int n, input step_t s);
        int         ar0;
        int         aw0;
        int         cycles;
        int         nb;
        logic [7:0] idx;
        logic [2:0] off;
        logic [2:0] code;
        idx  = s.addr[10:3];
        off  = s.addr[2:0];
        code = s.f3;
        nb   = 1 << code[1:0];
        @(negedge clk);
        ar0 = ar_count;
        aw0 = aw_count;
        @(posedge clk);
        inst      <= {s.op != op_store, s.op == op_store, s.f3};
        ex_data   <= s.addr;
        ex_data2  <= s.data;
        is_bubble <= (s.op == op_hold);
        if (s.op == op_hold) begin
            repeat (10) begin
                @(negedge clk);
                check_flag(1'b0, dcache_en, "dcache_en during bubble");
                check_flag(1'b0, dcache_valid || write_done, "completion during bubble");
            end
        end else begin
            cycles = 0;
            @(negedge clk);
            check_flag(1'b1, dcache_en, "dcache_en for an access");
            while (!dcache_valid && !write_done) begin
                cycles++;
                if (cycles == 200) begin
                    $display("timeout: step %0d saw no completion pulse in 200 cycles", n);
                    stop_run();
                end
                @(negedge clk);
            end
            check_flag(s.op == op_load, dcache_valid, "dcache_valid pulse");
            check_flag(s.op == op_store, write_done, "write_done pulse");
            if (s.op == op_store) begin
                for (int k = 0; k < nb; k++) begin
                    ref_mem[idx][8*(off+k) +: 8] = s.data[8*k +: 8];
                end
            end else if (s.f3 == mem_pkg::f3ls_d) begin
                check_data(ref_mem[idx], mem_ex_rdata, "double-word load");
            end else begin
                check_width_ext(s.f3, ref_mem[idx], off, mem_ex_rdata);
            end
        end
        check_count(ar0 + s.miss, ar_count, "AR handshakes");
        check_count(aw0 + (s.op == op_store), aw_count, "AW handshakes");
        // bubble before the next access
        @(posedge clk);
        inst      <= '0;
        is_bubble <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h57c7));
        clk       = 1'b0;
        rst_n     = 1'b0;
        inst      = '0;
        ex_data   = '0;
        ex_data2  = '0;
        is_bubble = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = mem.words[i];
        end
        @(negedge clk);
        check_flag(1'b0, dcache_m_axi_awvalid || dcache_m_axi_wvalid || dcache_m_axi_arvalid,
                   "request valids after reset");
        check_flag(1'b0, dcache_m_axi_bready || dcache_m_axi_rready,
                   "response readies after reset");
        check_flag(1'b0, dcache_valid || write_done, "completion pulses after reset");

        // every load width on unseen words
        add_step(op_load, mem_pkg::f3ls_b, 64'h00b, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_bu, 64'h015, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_h, 64'h01a, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_hu, 64'h026, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_w, 64'h02c, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_wu, 64'h030, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_d, 64'h038, 64'h0, 1'b1);
        // hits
        add_step(op_load, mem_pkg::f3ls_d, 64'h038, 64'h0, 1'b0);
        add_step(op_load, mem_pkg::f3ls_b, 64'h00f, 64'h0, 1'b0);
        add_step(op_load, mem_pkg::f3ls_hu, 64'h01e, 64'h0, 1'b0);
        // stores into cached words
        add_step(op_store, mem_pkg::f3ls_h, 64'h00c, 64'hffff_0000_aaaa_1234, 1'b0);
        add_step(op_load, mem_pkg::f3ls_d, 64'h008, 64'h0, 1'b0);
        add_step(op_store, mem_pkg::f3ls_b, 64'h03f, 64'h1111_2222_3333_4480, 1'b0);
        add_step(op_load, mem_pkg::f3ls_b, 64'h03f, 64'h0, 1'b0);
        add_step(op_store, mem_pkg::f3ls_w, 64'h028, 64'h0123_4567_89ab_cdef, 1'b0);
        add_step(op_load, mem_pkg::f3ls_wu, 64'h028, 64'h0, 1'b0);
        // stores of each size into uncached words
        add_step(op_store, mem_pkg::f3ls_b, 64'h101, 64'hdead_beef_cafe_00a5, 1'b0);
        add_step(op_store, mem_pkg::f3ls_h, 64'h10a, 64'h7777_6666_5555_beef, 1'b0);
        add_step(op_store, mem_pkg::f3ls_w, 64'h114, 64'h5a5a_5a5a_8765_4321, 1'b0);
        add_step(op_store, mem_pkg::f3ls_d, 64'h118, 64'h0123_4567_89ab_cdef, 1'b0);
        add_step(op_load, mem_pkg::f3ls_d, 64'h100, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_d, 64'h108, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_d, 64'h110, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_h, 64'h11e, 64'h0, 1'b1);
        // index 8 shared by two tags
        add_step(op_load, mem_pkg::f3ls_d, 64'h040, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_d, 64'h440, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_w, 64'h044, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_wu, 64'h444, 64'h0, 1'b1);
        add_step(op_load, mem_pkg::f3ls_d, 64'h440, 64'h0, 1'b0);
        // load held under a bubble
        add_step(op_hold, mem_pkg::f3ls_d, 64'h040, 64'h0, 1'b0);
        add_step(op_load, mem_pkg::f3ls_d, 64'h040, 64'h0, 1'b1);

        foreach (steps[i]) begin
            run_step(i, steps[i]);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/mem_pkg.sv
src/dcache_req_if.sv
src/mem_stage.sv
src/dcache.sv
src/mem_subsystem_top.sv
sim/axi_mem_model.sv
sim/tb_mem_subsystem.sv
